/* issue_settings.svh */
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Datapath widths
`define ISSUE_DATA_W 16
`define ISSUE_TAG_W 3    // ROB has eight entries
`define ISSUE_REG_W 3    // R0 to R7
`define ISSUE_OPCODE_W 4

// Instruction fields
`define ISSUE_IMM_W 5    // imm5 of ADD/AND/NOT
`define ISSUE_OFF_W 6    // offset6 of LDR/STR

// Back end resources
`define ISSUE_NUM_ALU_RS 3
`define ISSUE_RS_ID_W 2  // Enough to index every ALU station

`endif

/* issue_pkg.sv */
package issue_pkg;

	`include "issue_settings.svh"

	typedef logic [`ISSUE_DATA_W-1:0] word_t;
	typedef logic [`ISSUE_TAG_W-1:0]  tag_t;   // ROB entry
	typedef logic [`ISSUE_REG_W-1:0]  reg_t;   // Architectural register

	// Only the kept opcodes are named, anything else decodes to cls_none
	typedef enum logic [`ISSUE_OPCODE_W-1:0] {
		op_add = 4'd1,
		op_and = 4'd5,
		op_ldr = 4'd6,
		op_str = 4'd7,
		op_not = 4'd9
	} opcode_e;

	// Where an instruction goes after issue
	typedef enum logic [1:0] {
		cls_none  = 2'd0,
		cls_alu   = 2'd1,
		cls_load  = 2'd2,
		cls_store = 2'd3
	} class_e;

	// Source operand as seen by a station or the load/store buffer
	// A ready operand carries its value, otherwise the tag of the ROB
	// entry that will produce it
	typedef struct packed {
		logic  ready;
		word_t value;
		tag_t  tag;
	} operand_t;

endpackage

/* issue_ifs.sv */
`timescale 1ns/1ps

// Fields of the instruction currently presented for issue
interface decoded_if
	import issue_pkg::*;
();
	opcode_e opcode;
	class_e  cls;         // ALU, load, store or none
	reg_t    dst;         // DR, or SR for a store
	logic    use_imm;     // Second ALU operand is imm5
	word_t   imm;         // Sign-extended imm5
	word_t   mem_offset;  // Sign-extended offset6, word scaled

	modport driver (
		output opcode,
		output cls,
		output dst,
		output use_imm,
		output imm,
		output mem_offset
	);

	modport reader (
		input opcode,
		input cls,
		input dst,
		input use_imm,
		input imm,
		input mem_offset
	);
endinterface

// Resolved source operands for one instruction
interface operand_if
	import issue_pkg::*;
();
	operand_t opa;   // ALU SR1
	operand_t opb;   // ALU SR2 or immediate
	operand_t base;  // Load/store base register
	operand_t src;   // Store data

	modport driver (
		output opa, opb, base, src
	);

	modport reader (
		input opa, opb, base, src
	);
endinterface

/* issue_decode.sv */
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_decode
	import issue_pkg::*;
(
	input word_t instr,
	decoded_if.driver dec
);

	localparam int IMM_PAD = `ISSUE_DATA_W - `ISSUE_IMM_W;
	localparam int OFF_PAD = `ISSUE_DATA_W - `ISSUE_OFF_W - 1;

	opcode_e opcode;
	logic    imm_sign;
	logic    off_sign;

	assign opcode   = opcode_e'(instr[15:12]);
	assign imm_sign = instr[`ISSUE_IMM_W-1];
	assign off_sign = instr[`ISSUE_OFF_W-1];

	assign dec.opcode = opcode;
	assign dec.dst    = instr[11:9];  // DR, SR for STR

	// Class of the opcode
	always_comb
	begin
		case (opcode)
			op_add, op_and, op_not:
			begin
				dec.cls = cls_alu;
			end
			op_ldr:
			begin
				dec.cls = cls_load;
			end
			op_str:
			begin
				dec.cls = cls_store;
			end
			default:
			begin
				dec.cls = cls_none;  // Dropped or unknown, never issued
			end
		endcase
	end

	// Bit 5 selects the immediate form, NOT always has it set
	assign dec.use_imm = (dec.cls == cls_alu) && instr[5];

	assign dec.imm = {{IMM_PAD{imm_sign}}, instr[`ISSUE_IMM_W-1:0]};

	// Byte address offset of a word access
	assign dec.mem_offset = {{OFF_PAD{off_sign}}, instr[`ISSUE_OFF_W-1:0], 1'b0};

endmodule

/* operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch
	import issue_pkg::*;
(
	decoded_if.reader dec,
	input logic sr1_busy,
	input logic sr2_busy,
	input logic dst_busy,
	input word_t sr1_data,
	input word_t sr2_data,
	input word_t dst_data,
	input tag_t sr1_tag,
	input tag_t sr2_tag,
	input tag_t dst_tag,
	input logic cdb_valid,
	input tag_t cdb_tag,
	input word_t cdb_data,
	input logic rob_sr1_valid,
	input logic rob_sr2_valid,
	input word_t rob_sr1_data,
	input word_t rob_sr2_data,
	operand_if.driver ops,
	output tag_t rob_sr2_addr
);

	operand_t sr1_op;

	// Register file first, then this cycle's CDB, then a finished ROB entry
	function automatic operand_t resolve(
		input logic  busy,
		input word_t reg_data,
		input tag_t  reg_tag,
		input logic  rob_valid,
		input word_t rob_data,
		input logic  bus_valid,
		input tag_t  bus_tag,
		input word_t bus_data
	);
		operand_t op;
		op.ready = 1'b1;
		op.value = reg_data;
		op.tag   = '0;
		if (busy)
		begin
			if (bus_valid && (bus_tag == reg_tag))
				op.value = bus_data;  // Forwarded from the CDB
			else if (rob_valid)
				op.value = rob_data;
			else
			begin
				op.ready = 1'b0;  // Wait for the producer
				op.value = '0;
				op.tag   = reg_tag;
			end
		end
		return op;
	endfunction

	// SR1 feeds both the ALU A side and the memory base
	assign sr1_op = resolve(sr1_busy, sr1_data, sr1_tag, rob_sr1_valid, rob_sr1_data,
		cdb_valid, cdb_tag, cdb_data);

	assign ops.opa  = sr1_op;
	assign ops.base = sr1_op;

	assign ops.opb = dec.use_imm ? operand_t'{ready: 1'b1, value: dec.imm, tag: '0}
		: resolve(sr2_busy, sr2_data, sr2_tag, rob_sr2_valid, rob_sr2_data,
			cdb_valid, cdb_tag, cdb_data);

	// Store data sits in the DR field, second ROB port looks it up
	assign ops.src = resolve(dst_busy, dst_data, dst_tag, rob_sr2_valid, rob_sr2_data,
		cdb_valid, cdb_tag, cdb_data);

	assign rob_sr2_addr = (dec.cls == cls_store) ? dst_tag : sr2_tag;

endmodule

/* issue_dispatch.sv */
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_dispatch
	import issue_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	decoded_if.reader dec,
	operand_if.reader ops,
	input logic rob_full,
	input logic lsb_full,
	input logic [`ISSUE_NUM_ALU_RS-1:0] alu_rs_busy,
	input tag_t rob_tail,
	output logic stall,
	// ALU reservation station
	output logic rs_write,
	output logic [`ISSUE_RS_ID_W-1:0] rs_id,
	output opcode_e rs_op,
	output operand_t rs_opa,
	output operand_t rs_opb,
	output tag_t rs_dest,
	// Load/store buffer
	output logic lsb_write,
	output logic lsb_is_store,
	output word_t lsb_offset,
	output operand_t lsb_base,
	output operand_t lsb_src,
	output tag_t lsb_dest,
	// Reorder buffer
	output logic rob_write,
	output opcode_e rob_op,
	output reg_t rob_dest_reg,
	// Register file status
	output logic reg_busy_write,
	output reg_t reg_busy_reg,
	output tag_t reg_busy_tag
);

	localparam int RS_ID_W = `ISSUE_RS_ID_W;

	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_mem;
	logic accept;
	logic [RS_ID_W-1:0] free_id;

	assign is_alu   = (dec.cls == cls_alu);
	assign is_load  = (dec.cls == cls_load);
	assign is_store = (dec.cls == cls_store);
	assign is_mem   = is_load || is_store;

	// Discarded opcodes never hold up fetch
	assign stall = instr_valid && (
		(rob_full && (dec.cls != cls_none)) ||
		(is_alu && (&alu_rs_busy)) ||
		(is_mem && lsb_full));

	assign accept = instr_valid && !stall;

	// Lowest numbered free station wins
	always_comb
	begin
		free_id = '0;
		for (int i = `ISSUE_NUM_ALU_RS - 1; i >= 0; i--)
		begin
			if (!alu_rs_busy[i])
				free_id = RS_ID_W'(i);
		end
	end

	// One cycle strobes
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rs_write       <= 1'b0;
			lsb_write      <= 1'b0;
			rob_write      <= 1'b0;
			reg_busy_write <= 1'b0;
		end
		else
		begin
			rs_write       <= accept && is_alu;
			lsb_write      <= accept && is_mem;
			rob_write      <= accept && (dec.cls != cls_none);
			reg_busy_write <= accept && (is_alu || is_load);  // Stores write no register
		end
	end

	// Payload, held until the next accepted instruction
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			rs_id   <= free_id;
			rs_op   <= dec.opcode;
			rs_opa  <= ops.opa;
			rs_opb  <= ops.opb;
			rs_dest <= rob_tail;

			lsb_is_store <= is_store;
			lsb_offset   <= dec.mem_offset;
			lsb_base     <= ops.base;
			lsb_src      <= is_store ? ops.src : '0;
			lsb_dest     <= is_store ? '0 : rob_tail;  // Store results go nowhere

			rob_op       <= dec.opcode;
			rob_dest_reg <= is_store ? '0 : dec.dst;

			reg_busy_reg <= dec.dst;
			reg_busy_tag <= rob_tail;
		end
	end

endmodule

/* issue_unit.sv */
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_unit
	import issue_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// Fetch
	input word_t instr,
	input logic instr_valid,
	output logic stall,
	// Register file reads
	output reg_t sr1_addr,
	output reg_t sr2_addr,
	output reg_t dst_addr,
	input logic sr1_busy,
	input word_t sr1_data,
	input tag_t sr1_tag,
	input logic sr2_busy,
	input word_t sr2_data,
	input tag_t sr2_tag,
	input logic dst_busy,
	input word_t dst_data,
	input tag_t dst_tag,
	// Common data bus
	input logic cdb_valid,
	input tag_t cdb_tag,
	input word_t cdb_data,
	// ROB lookups and allocation
	output tag_t rob_sr1_addr,
	output tag_t rob_sr2_addr,
	input logic rob_sr1_valid,
	input word_t rob_sr1_data,
	input logic rob_sr2_valid,
	input word_t rob_sr2_data,
	input logic rob_full,
	input tag_t rob_tail,
	// Back end status
	input logic [`ISSUE_NUM_ALU_RS-1:0] alu_rs_busy,
	input logic lsb_full,
	// ALU reservation station
	output logic rs_write,
	output logic [`ISSUE_RS_ID_W-1:0] rs_id,
	output opcode_e rs_op,
	output operand_t rs_opa,
	output operand_t rs_opb,
	output tag_t rs_dest,
	// Load/store buffer
	output logic lsb_write,
	output logic lsb_is_store,
	output word_t lsb_offset,
	output operand_t lsb_base,
	output operand_t lsb_src,
	output tag_t lsb_dest,
	// ROB write
	output logic rob_write,
	output opcode_e rob_op,
	output reg_t rob_dest_reg,
	// Register busy update
	output logic reg_busy_write,
	output reg_t reg_busy_reg,
	output tag_t reg_busy_tag
);

	decoded_if dec_bus ();
	operand_if op_bus ();

	assign sr1_addr     = instr[8:6];
	assign sr2_addr     = instr[2:0];
	assign dst_addr     = instr[11:9];
	assign rob_sr1_addr = sr1_tag;

	issue_decode issue_decode_inst (
		.instr (instr),
		.dec   (dec_bus)
	);

	operand_fetch operand_fetch_inst (
		.dec           (dec_bus),
		.sr1_busy      (sr1_busy),
		.sr2_busy      (sr2_busy),
		.dst_busy      (dst_busy),
		.sr1_data      (sr1_data),
		.sr2_data      (sr2_data),
		.dst_data      (dst_data),
		.sr1_tag       (sr1_tag),
		.sr2_tag       (sr2_tag),
		.dst_tag       (dst_tag),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_data      (cdb_data),
		.rob_sr1_valid (rob_sr1_valid),
		.rob_sr2_valid (rob_sr2_valid),
		.rob_sr1_data  (rob_sr1_data),
		.rob_sr2_data  (rob_sr2_data),
		.ops           (op_bus),
		.rob_sr2_addr  (rob_sr2_addr)
	);

	issue_dispatch issue_dispatch_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.dec            (dec_bus),
		.ops            (op_bus),
		.rob_full       (rob_full),
		.lsb_full       (lsb_full),
		.alu_rs_busy    (alu_rs_busy),
		.rob_tail       (rob_tail),
		.stall          (stall),
		.rs_write       (rs_write),
		.rs_id          (rs_id),
		.rs_op          (rs_op),
		.rs_opa         (rs_opa),
		.rs_opb         (rs_opb),
		.rs_dest        (rs_dest),
		.lsb_write      (lsb_write),
		.lsb_is_store   (lsb_is_store),
		.lsb_offset     (lsb_offset),
		.lsb_base       (lsb_base),
		.lsb_src        (lsb_src),
		.lsb_dest       (lsb_dest),
		.rob_write      (rob_write),
		.rob_op         (rob_op),
		.rob_dest_reg   (rob_dest_reg),
		.reg_busy_write (reg_busy_write),
		.reg_busy_reg   (reg_busy_reg),
		.reg_busy_tag   (reg_busy_tag)
	);

endmodule

/* tb_issue_unit.sv */
`timescale 1ns/1ps

`include "issue_settings.svh"

module tb_issue_unit
	import issue_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 6;
	localparam int ACCEPT_LIMIT = 10;  // Cycles a held instruction may stall

	logic clk;
	logic rst_n;
	word_t instr;
	logic instr_valid;
	logic stall;
	reg_t sr1_addr, sr2_addr, dst_addr;
	logic sr1_busy, sr2_busy, dst_busy;
	word_t sr1_data, sr2_data, dst_data;
	tag_t sr1_tag, sr2_tag, dst_tag;
	logic cdb_valid;
	tag_t cdb_tag;
	word_t cdb_data;
	tag_t rob_sr1_addr, rob_sr2_addr;
	logic rob_sr1_valid, rob_sr2_valid;
	word_t rob_sr1_data, rob_sr2_data;
	logic rob_full;
	tag_t rob_tail;
	logic [`ISSUE_NUM_ALU_RS-1:0] alu_rs_busy;
	logic lsb_full;
	logic rs_write;
	logic [`ISSUE_RS_ID_W-1:0] rs_id;
	opcode_e rs_op;
	operand_t rs_opa, rs_opb;
	tag_t rs_dest;
	logic lsb_write, lsb_is_store;
	word_t lsb_offset;
	operand_t lsb_base, lsb_src;
	tag_t lsb_dest;
	logic rob_write;
	opcode_e rob_op;
	reg_t rob_dest_reg;
	logic reg_busy_write;
	reg_t reg_busy_reg;
	tag_t reg_busy_tag;

	int seed = 5680;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int test_start_errors;
	string test_name;

	issue_unit issue_unit_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(NUM_TESTS * 20 * CLK_PERIOD);
		$display("Timeout: the testbench did not finish in time");
		$display("Checks failed");
		$finish;
	end

	// LC-3 style encodings
	function automatic word_t alu_instr(input opcode_e op, input reg_t dr, input reg_t sr1,
		input logic imm_form, input logic [4:0] low);
		return {op, dr, sr1, imm_form, low};
	endfunction

	function automatic word_t mem_instr(input opcode_e op, input reg_t dr, input reg_t base,
		input logic [5:0] off);
		return {op, dr, base, off};
	endfunction

	function automatic word_t sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic word_t scaled_off(input logic [5:0] v);
		return {{9{v[5]}}, v, 1'b0};  // Word offset as a byte offset
	endfunction

	function automatic operand_t make_operand(input logic r, input word_t v, input tag_t t);
		operand_t op;
		op.ready = r;
		op.value = v;
		op.tag   = t;
		return op;
	endfunction

	task automatic check_val(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
		end
	endtask

	// Value matters only when ready, tag only when waiting
	task automatic check_operand(input string what, input operand_t expected,
		input operand_t actual);
		check_val({what, ".ready"}, 32'(expected.ready), 32'(actual.ready));
		if (expected.ready)
			check_val({what, ".value"}, 32'(expected.value), 32'(actual.value));
		else
			check_val({what, ".tag"}, 32'(expected.tag), 32'(actual.tag));
	endtask

	task automatic check_strobes(input logic [3:0] expected);
		check_val("strobes rs/lsb/rob/busy", 32'(expected),
			32'({rs_write, lsb_write, rob_write, reg_busy_write}));
	endtask

	task automatic report(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic clear_inputs();
		instr = '0;
		instr_valid = 1'b0;
		sr1_busy = 1'b0;
		sr2_busy = 1'b0;
		dst_busy = 1'b0;
		sr1_data = '0;
		sr2_data = '0;
		dst_data = '0;
		sr1_tag = '0;
		sr2_tag = '0;
		dst_tag = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		rob_sr1_valid = 1'b0;
		rob_sr2_valid = 1'b0;
		rob_sr1_data = '0;
		rob_sr2_data = '0;
		rob_full = 1'b0;
		rob_tail = '0;
		alu_rs_busy = '0;
		lsb_full = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = errors;
		clear_inputs();
	endtask

	task automatic end_test();
		tests_run++;
		$display("%-10s %s", test_name, (errors == test_start_errors) ? "PASS" : "FAIL");
	endtask

	// Hold the instruction until taken, return one cycle after the accept edge
	task automatic issue(input word_t ins);
		int waited;
		waited = 0;
		instr = ins;
		instr_valid = 1'b1;
		#1;
		while (stall && waited < ACCEPT_LIMIT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (!stall)
		else
			report("instruction was never accepted");
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	// Strobes must drop after one cycle
	task automatic check_idle();
		@(posedge clk);
		#1;
		check_strobes(4'b0000);
	endtask

	// One held cycle that must not issue anything
	task automatic hold_stalled(input string what, input word_t ins, input logic exp_stall);
		instr = ins;
		instr_valid = 1'b1;
		#1;
		check_val({what, " stall"}, 32'(exp_stall), 32'(stall));
		@(posedge clk);
		#1;
		check_strobes(4'b0000);
	endtask

	task automatic test_add_imm();
		word_t a;
		start_test("add_imm");
		a = word_t'($random(seed));
		sr1_data = a;
		rob_tail = 3'd5;
		issue(alu_instr(op_add, 3'd2, 3'd1, 1'b1, 5'b10110));
		check_val("sr1_addr", 1, 32'(sr1_addr));
		check_val("dst_addr", 2, 32'(dst_addr));
		check_strobes(4'b1011);
		check_val("rs_op", 32'(op_add), 32'(rs_op));
		check_operand("rs_opa", make_operand(1'b1, a, 3'd0), rs_opa);
		check_operand("rs_opb", make_operand(1'b1, sext5(5'b10110), 3'd0), rs_opb);
		check_val("rs_dest", 5, 32'(rs_dest));
		check_val("reg_busy_reg", 2, 32'(reg_busy_reg));
		check_val("reg_busy_tag", 5, 32'(reg_busy_tag));
		check_val("rob_dest_reg", 2, 32'(rob_dest_reg));
		check_idle();
		end_test();
	endtask

	task automatic test_and_reg();
		word_t bus_d;
		word_t rob_d;
		word_t ins;
		start_test("and_reg");
		bus_d = word_t'($random(seed));
		rob_d = word_t'($random(seed));
		ins = alu_instr(op_and, 3'd4, 3'd3, 1'b0, {2'b00, 3'd6});
		sr1_busy = 1'b1;
		sr1_tag = 3'd3;
		sr1_data = word_t'($random(seed));  // Stale copy that must be ignored
		cdb_valid = 1'b1;
		cdb_tag = 3'd3;
		cdb_data = bus_d;
		sr2_busy = 1'b1;
		sr2_tag = 3'd6;
		rob_sr2_valid = 1'b1;
		rob_sr2_data = rob_d;
		rob_tail = 3'd1;
		issue(ins);
		check_val("sr2_addr", 6, 32'(sr2_addr));
		check_val("rob_sr1_addr", 3, 32'(rob_sr1_addr));
		check_val("rob_sr2_addr", 6, 32'(rob_sr2_addr));
		check_strobes(4'b1011);
		check_val("rs_op", 32'(op_and), 32'(rs_op));
		check_operand("rs_opa cdb", make_operand(1'b1, bus_d, 3'd0), rs_opa);
		check_operand("rs_opb rob", make_operand(1'b1, rob_d, 3'd0), rs_opb);
		check_idle();
		cdb_valid = 1'b0;
		rob_sr2_valid = 1'b0;
		issue(ins);
		check_operand("rs_opa wait", make_operand(1'b0, '0, 3'd3), rs_opa);
		check_operand("rs_opb wait", make_operand(1'b0, '0, 3'd6), rs_opb);
		check_idle();
		end_test();
	endtask

	task automatic test_rs_select();
		logic [`ISSUE_NUM_ALU_RS-1:0] pat [3] = '{3'b000, 3'b001, 3'b011};
		word_t ins;
		start_test("rs_select");
		ins = alu_instr(op_not, 3'd1, 3'd2, 1'b1, 5'h1f);
		for (int i = 0; i < 3; i++)
		begin
			alu_rs_busy = pat[i];
			issue(ins);
			check_val("rs_id", i, 32'(rs_id));
			check_idle();
		end
		alu_rs_busy = 3'b111;
		hold_stalled("all busy", ins, 1'b1);
		hold_stalled("all busy", ins, 1'b1);
		alu_rs_busy = 3'b101;  // Station 1 frees
		issue(ins);
		check_strobes(4'b1011);
		check_val("rs_id freed", 1, 32'(rs_id));
		check_idle();
		end_test();
	endtask

	task automatic test_ldr();
		word_t base;
		start_test("ldr");
		base = word_t'($random(seed));
		sr1_data = base;
		rob_tail = 3'd7;
		issue(mem_instr(op_ldr, 3'd3, 3'd5, 6'b111101));
		check_strobes(4'b0111);
		check_val("lsb_is_store", 0, 32'(lsb_is_store));
		check_val("lsb_offset", 32'(scaled_off(6'b111101)), 32'(lsb_offset));
		check_operand("lsb_base", make_operand(1'b1, base, 3'd0), lsb_base);
		check_val("lsb_dest", 7, 32'(lsb_dest));
		check_val("reg_busy_tag", 7, 32'(reg_busy_tag));
		check_idle();
		sr1_busy = 1'b1;
		sr1_tag = 3'd2;
		issue(mem_instr(op_ldr, 3'd3, 3'd5, 6'd4));
		check_val("lsb_offset", 32'(scaled_off(6'd4)), 32'(lsb_offset));
		check_operand("lsb_base wait", make_operand(1'b0, '0, 3'd2), lsb_base);
		check_idle();
		end_test();
	endtask

	task automatic test_str();
		word_t d;
		word_t rob_d;
		word_t ins;
		start_test("str");
		d = word_t'($random(seed));
		rob_d = word_t'($random(seed));
		ins = mem_instr(op_str, 3'd6, 3'd1, 6'd3);
		dst_data = d;
		dst_tag = 3'd4;
		sr2_tag = 3'd1;
		rob_tail = 3'd2;
		issue(ins);
		check_val("rob_sr2_addr", 4, 32'(rob_sr2_addr));  // Store source tag, not sr2
		check_strobes(4'b0110);
		check_val("lsb_is_store", 1, 32'(lsb_is_store));
		check_operand("lsb_src", make_operand(1'b1, d, 3'd0), lsb_src);
		check_val("lsb_dest", 0, 32'(lsb_dest));
		check_val("rob_op", 32'(op_str), 32'(rob_op));
		check_val("rob_dest_reg", 0, 32'(rob_dest_reg));
		check_idle();
		dst_busy = 1'b1;
		rob_sr2_valid = 1'b1;
		rob_sr2_data = rob_d;
		issue(ins);
		check_operand("lsb_src rob", make_operand(1'b1, rob_d, 3'd0), lsb_src);
		check_idle();
		end_test();
	endtask

	task automatic test_stall();
		start_test("stall");
		rob_full = 1'b1;
		hold_stalled("rob_full add", alu_instr(op_add, 3'd1, 3'd1, 1'b1, 5'd1), 1'b1);
		hold_stalled("rob_full ldr", mem_instr(op_ldr, 3'd1, 3'd2, 6'd0), 1'b1);
		hold_stalled("jmp", 16'hc1c0, 1'b0);  // Dropped opcode is discarded
		rob_full = 1'b0;
		lsb_full = 1'b1;
		hold_stalled("lsb_full ldr", mem_instr(op_ldr, 3'd1, 3'd2, 6'd0), 1'b1);
		hold_stalled("lsb_full str", mem_instr(op_str, 3'd1, 3'd2, 6'd0), 1'b1);
		issue(alu_instr(op_add, 3'd1, 3'd1, 1'b1, 5'd1));
		check_strobes(4'b1011);
		check_idle();
		end_test();
	endtask

	initial
	begin
		clear_inputs();
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_name = "reset";
		check_strobes(4'b0000);
		test_add_imm();
		test_and_reg();
		test_rs_select();
		test_ldr();
		test_str();
		test_stall();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
issue_pkg.sv
issue_ifs.sv
issue_decode.sv
operand_fetch.sv
issue_dispatch.sv
issue_unit.sv
tb_issue_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the issue stage testbench, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_issue_unit \
	-o tb_issue_unit \
	&& ./obj_dir/tb_issue_unit 2>&1 | tee sim.log \
	&& grep -q "All checks passed" sim.log \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
